//--- source/lsu_config.svh
/* replay subsystem sizing: queue depth, payload width,
   store-queue and miss-unit sizes, one-hot hazard index width */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// replay queue entries
`define LSU_RQ_DEPTH 8

// opaque memory op payload carried through the queue
`define LSU_PAYLOAD_W 32

// hazard sources
`define LSU_STQ_SIZE 8
`define LSU_MISSU_SIZE 8

// one-hot hazard index, wide enough for either source
`define LSU_HAZ_INDEX_W \
  ((`LSU_STQ_SIZE > `LSU_MISSU_SIZE) ? `LSU_STQ_SIZE : `LSU_MISSU_SIZE)

`endif

//--- source/lsu_pkg.sv
/* shared types: hazard type and arbiter grant state */
`default_nettype none

package lsu_pkg;

  // --------------------------------------------------------------------
  // hazard classes
  // --------------------------------------------------------------------

  // recorded per replay entry, picks the clearing condition
  typedef enum logic [2:0] {
    HAZ_STQ_NONFWD     = 3'd0,  // store data not forwardable yet
    HAZ_L1D_CONFLICT   = 3'd1,
    HAZ_MISSU_FULL     = 3'd2,
    HAZ_MISSU_ASSIGNED = 3'd3   // waiting on its own miss entry
  } haz_type_e;

  // --------------------------------------------------------------------
  // arbiter grant
  // --------------------------------------------------------------------

  // what currently sits in the output slot
  typedef enum logic [1:0] {
    SEL_IDLE   = 2'd0,
    SEL_NEW    = 2'd1,
    SEL_REPLAY = 2'd2
  } arb_sel_e;

endpackage

`default_nettype wire

//--- source/ring_fifo.sv
/* circular FIFO with occupancy count, combinational read of the oldest entry */
`timescale 1ns/10ps
`default_nettype none

module ring_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty,
  output logic             o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] r_mem [DEPTH];
  logic [PTR_W-1:0] r_head;
  logic [PTR_W-1:0] r_tail;
  logic [CNT_W-1:0] r_count;
  logic             w_do_push;
  logic             w_do_pop;

  assign w_do_push = i_push & ~o_full;
  assign w_do_pop  = i_pop & ~o_empty;

  assign o_empty = (r_count == '0);
  assign o_full  = (r_count == CNT_W'(DEPTH));
  assign o_data  = r_mem[r_head];

  always_ff @(posedge i_clk) begin
    if (w_do_push) begin
      r_mem[r_tail] <= i_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      if (w_do_push) begin
        r_tail <= (r_tail == PTR_W'(DEPTH - 1)) ? '0 : r_tail + 1'b1;
      end
      if (w_do_pop) begin
        r_head <= (r_head == PTR_W'(DEPTH - 1)) ? '0 : r_head + 1'b1;
      end
      case ({w_do_push, w_do_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  a_no_over_under: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_push && o_full) && !(i_pop && o_empty))
    else $error("ring_fifo push while full or pop while empty");

endmodule

`default_nettype wire

//--- source/lsu_replay_queue.sv
/* replay queue: parks hazarded memory ops, tracks hazard resolution per entry,
   times out on push gaps, marks entries dead on flush, requests replay */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_config.svh"

module lsu_replay_queue (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  // hazard push from execute
  input  logic                          i_haz_valid,
  input  logic [`LSU_PAYLOAD_W-1:0]     i_haz_payload,
  input  lsu_pkg::haz_type_e            i_haz_type,
  input  logic [`LSU_HAZ_INDEX_W-1:0]   i_haz_index,
  output logic                          o_haz_full,
  // resolve sources
  input  logic                          i_missu_full,
  input  logic                          i_missu_resolve_valid,
  input  logic [`LSU_HAZ_INDEX_W-1:0]   i_missu_resolve_oh,
  input  logic [`LSU_HAZ_INDEX_W-1:0]   i_missu_entry_valids,
  input  logic [`LSU_HAZ_INDEX_W-1:0]   i_stq_resolve_mask,
  input  logic                          i_flush,
  // replay request to arbiter
  output logic                          o_rq_valid,
  output logic [`LSU_PAYLOAD_W-1:0]     o_rq_payload,
  input  logic                          i_rq_ready
);

  import lsu_pkg::*;

  localparam int DEPTH = `LSU_RQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int GAP_W = $clog2(DEPTH) + 2;
  localparam int PLD_W = `LSU_PAYLOAD_W;
  localparam int IDX_W = `LSU_HAZ_INDEX_W;
  localparam logic [GAP_W-1:0] GAP_MAX = '1;

  logic                   w_push;
  logic                   w_pop;
  logic                   w_empty;
  logic                   w_full;
  logic [GAP_W+PLD_W-1:0] w_fifo_wdata;
  logic [GAP_W+PLD_W-1:0] w_fifo_rdata;
  logic [GAP_W-1:0]       w_head_gap;
  logic                   w_head_live;
  logic                   w_head_dead;
  logic                   w_head_timeout;

  // cycles since the previous push, and since the last pop
  logic [GAP_W-1:0]       r_push_gap;
  logic [GAP_W-1:0]       r_pop_wait;

  logic [PTR_W-1:0]       r_wr_ptr;
  logic [PTR_W-1:0]       r_rd_ptr;

  // side state, same slot order as the payload FIFO
  logic                   r_valid     [DEPTH];
  logic                   r_dead      [DEPTH];
  logic                   r_resolved  [DEPTH];
  haz_type_e              r_haz_type  [DEPTH];
  logic [IDX_W-1:0]       r_haz_index [DEPTH];
  logic [DEPTH-1:0]       w_clear;

  // --------------------------------------------------------------------
  // push / pop
  // --------------------------------------------------------------------

  assign w_push = i_haz_valid & ~w_full;

  // dead head leaves without a request
  assign w_head_dead = ~w_empty & r_valid[r_rd_ptr] & r_dead[r_rd_ptr];
  assign w_pop       = w_head_dead | (o_rq_valid & i_rq_ready);

  // first entry into an empty queue has no predecessor, gap 0
  assign w_fifo_wdata = {(w_empty ? '0 : r_push_gap), i_haz_payload};

  ring_fifo #(
    .WIDTH (GAP_W + PLD_W),
    .DEPTH (DEPTH)
  ) u_payload_fifo (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_push    (w_push),
    .i_data    (w_fifo_wdata),
    .i_pop     (w_pop),
    .o_data    (w_fifo_rdata),
    .o_empty   (w_empty),
    .o_full    (w_full)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------
  // gap and wait counters, both saturate
  // --------------------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_push_gap <= '0;
      r_pop_wait <= '0;
    end else begin
      if (w_push || w_empty) begin
        r_push_gap <= GAP_W'(1);
      end else if (r_push_gap != GAP_MAX) begin
        r_push_gap <= r_push_gap + 1'b1;
      end
      if (w_pop) begin
        r_pop_wait <= GAP_W'(1);
      end else if (w_push && w_empty) begin
        r_pop_wait <= '0;
      end else if (r_pop_wait != GAP_MAX) begin
        r_pop_wait <= r_pop_wait + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------
  // per-entry hazard tracking
  // --------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      case (r_haz_type[i])
        HAZ_STQ_NONFWD:     w_clear[i] = (r_haz_index[i] & ~i_stq_resolve_mask) == '0;
        HAZ_L1D_CONFLICT:   w_clear[i] = 1'b1;
        HAZ_MISSU_FULL:     w_clear[i] = ~i_missu_full;
        // own miss entry resolved, or it no longer exists
        HAZ_MISSU_ASSIGNED: w_clear[i] =
          (i_missu_resolve_valid && (i_missu_resolve_oh == r_haz_index[i])) ||
          ((r_haz_index[i] & i_missu_entry_valids) == '0);
        default:            w_clear[i] = 1'b0;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        r_valid[i]    <= 1'b0;
        r_dead[i]     <= 1'b0;
        r_resolved[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (w_push && (r_wr_ptr == PTR_W'(i))) begin
          r_valid[i]    <= 1'b1;
          // an op arriving with the flush is flushed too
          r_dead[i]     <= i_flush;
          r_resolved[i] <= 1'b0;
        end else if (w_pop && (r_rd_ptr == PTR_W'(i))) begin
          r_valid[i] <= 1'b0;
          r_dead[i]  <= 1'b0;
        end else if (r_valid[i]) begin
          if (i_flush) begin
            r_dead[i] <= 1'b1;
          end
          r_resolved[i] <= r_resolved[i] | w_clear[i];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_haz_type[r_wr_ptr]  <= i_haz_type;
      r_haz_index[r_wr_ptr] <= i_haz_index;
    end
  end

  // --------------------------------------------------------------------
  // head request
  // --------------------------------------------------------------------

  assign w_head_gap  = w_fifo_rdata[GAP_W+PLD_W-1:PLD_W];
  assign w_head_live = ~w_empty & r_valid[r_rd_ptr] & ~r_dead[r_rd_ptr];

  // gap 0 means pushed into an empty queue, so wait for saturation
  assign w_head_timeout = (w_head_gap == '0) ? (r_pop_wait == GAP_MAX)
                                             : (r_pop_wait >= w_head_gap);

  assign o_rq_valid   = w_head_live & (r_resolved[r_rd_ptr] | w_head_timeout);
  assign o_rq_payload = w_fifo_rdata[PLD_W-1:0];
  assign o_haz_full   = w_full;

  a_push_not_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_haz_full |-> !i_haz_valid)
    else $error("hazard push while replay queue is full");

  // an offered replay stays offered until taken, unless flushed
  a_rq_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_rq_valid && !i_rq_ready && !i_flush |=> o_rq_valid && $stable(o_rq_payload))
    else $error("replay request dropped before handshake");

endmodule

`default_nettype wire

//--- source/lsu_pipe_arbiter.sv
/* single pipe slot arbiter, replay over new issue, registered output */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_config.svh"

module lsu_pipe_arbiter (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_rq_valid,
  input  logic [`LSU_PAYLOAD_W-1:0] i_rq_payload,
  output logic                      o_rq_ready,
  input  logic                      i_new_valid,
  input  logic [`LSU_PAYLOAD_W-1:0] i_new_payload,
  output logic                      o_new_ready,
  output logic                      o_pipe_valid,
  output logic [`LSU_PAYLOAD_W-1:0] o_pipe_payload,
  output logic                      o_pipe_is_replay,
  input  logic                      i_pipe_ready
);

  import lsu_pkg::*;

  arb_sel_e                  r_sel;
  arb_sel_e                  w_sel_nxt;
  logic [`LSU_PAYLOAD_W-1:0] r_payload;

  // slot only refills while downstream takes
  assign o_rq_ready  = i_pipe_ready;
  assign o_new_ready = i_pipe_ready & ~i_rq_valid;

  always_comb begin
    if (i_rq_valid) begin
      w_sel_nxt = SEL_REPLAY;
    end else if (i_new_valid) begin
      w_sel_nxt = SEL_NEW;
    end else begin
      w_sel_nxt = SEL_IDLE;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_sel <= SEL_IDLE;
    end else if (i_pipe_ready) begin
      r_sel <= w_sel_nxt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_pipe_ready && (w_sel_nxt != SEL_IDLE)) begin
      r_payload <= (w_sel_nxt == SEL_REPLAY) ? i_rq_payload : i_new_payload;
    end
  end

  assign o_pipe_valid     = (r_sel != SEL_IDLE);
  assign o_pipe_is_replay = (r_sel == SEL_REPLAY);
  assign o_pipe_payload   = r_payload;

  a_slot_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_pipe_valid && !i_pipe_ready |=>
      o_pipe_valid && $stable(o_pipe_payload) && $stable(o_pipe_is_replay))
    else $error("pipe slot changed while stalled");

endmodule

`default_nettype wire

//--- source/lsu_replay_top.sv
/* LSU replay subsystem top: replay queue feeding the pipe arbiter */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_config.svh"

module lsu_replay_top (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  // hazard push from execute
  input  logic                          i_haz_valid,
  input  logic [`LSU_PAYLOAD_W-1:0]     i_haz_payload,
  input  lsu_pkg::haz_type_e            i_haz_type,
  input  logic [`LSU_HAZ_INDEX_W-1:0]   i_haz_index,
  output logic                          o_haz_full,
  // resolve sources
  input  logic                          i_missu_full,
  input  logic                          i_missu_resolve_valid,
  input  logic [`LSU_HAZ_INDEX_W-1:0]   i_missu_resolve_oh,
  input  logic [`LSU_HAZ_INDEX_W-1:0]   i_missu_entry_valids,
  input  logic [`LSU_HAZ_INDEX_W-1:0]   i_stq_resolve_mask,
  input  logic                          i_flush,
  // new issue
  input  logic                          i_new_valid,
  input  logic [`LSU_PAYLOAD_W-1:0]     i_new_payload,
  output logic                          o_new_ready,
  // pipe slot
  output logic                          o_pipe_valid,
  output logic [`LSU_PAYLOAD_W-1:0]     o_pipe_payload,
  output logic                          o_pipe_is_replay,
  input  logic                          i_pipe_ready
);

  // replay request between queue and arbiter
  logic                      w_rq_valid;
  logic [`LSU_PAYLOAD_W-1:0] w_rq_payload;
  logic                      w_rq_ready;

  lsu_replay_queue u_replay_queue (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_haz_valid           (i_haz_valid),
    .i_haz_payload         (i_haz_payload),
    .i_haz_type            (i_haz_type),
    .i_haz_index           (i_haz_index),
    .o_haz_full            (o_haz_full),
    .i_missu_full          (i_missu_full),
    .i_missu_resolve_valid (i_missu_resolve_valid),
    .i_missu_resolve_oh    (i_missu_resolve_oh),
    .i_missu_entry_valids  (i_missu_entry_valids),
    .i_stq_resolve_mask    (i_stq_resolve_mask),
    .i_flush               (i_flush),
    .o_rq_valid            (w_rq_valid),
    .o_rq_payload          (w_rq_payload),
    .i_rq_ready            (w_rq_ready)
  );

  lsu_pipe_arbiter u_pipe_arbiter (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_rq_valid       (w_rq_valid),
    .i_rq_payload     (w_rq_payload),
    .o_rq_ready       (w_rq_ready),
    .i_new_valid      (i_new_valid),
    .i_new_payload    (i_new_payload),
    .o_new_ready      (o_new_ready),
    .o_pipe_valid     (o_pipe_valid),
    .o_pipe_payload   (o_pipe_payload),
    .o_pipe_is_replay (o_pipe_is_replay),
    .i_pipe_ready     (i_pipe_ready)
  );

endmodule

`default_nettype wire

//--- bench/tb_lsu_replay.sv
/* testbench for the LSU replay subsystem: golden-file playback, output
   compare against expect records, random pipe stalls, cycle watchdog */
`timescale 1ns/10ps
`default_nettype none
`include "lsu_config.svh"

module tb_lsu_replay;

  import lsu_pkg::*;

  localparam int PLD_W = `LSU_PAYLOAD_W;
  localparam int IDX_W = `LSU_HAZ_INDEX_W;

  logic             i_clk;
  logic             i_reset_n;
  logic             i_haz_valid;
  logic [PLD_W-1:0] i_haz_payload;
  haz_type_e        i_haz_type;
  logic [IDX_W-1:0] i_haz_index;
  logic             o_haz_full;
  logic             i_missu_full;
  logic             i_missu_resolve_valid;
  logic [IDX_W-1:0] i_missu_resolve_oh;
  logic [IDX_W-1:0] i_missu_entry_valids;
  logic [IDX_W-1:0] i_stq_resolve_mask;
  logic             i_flush;
  logic             i_new_valid;
  logic [PLD_W-1:0] i_new_payload;
  logic             o_new_ready;
  logic             o_pipe_valid;
  logic [PLD_W-1:0] o_pipe_payload;
  logic             o_pipe_is_replay;
  logic             i_pipe_ready;

  // drive records, and expected outputs in file order
  logic [7:0]       rec_cmd [$];
  logic [31:0]      rec_a   [$];
  logic [31:0]      rec_b   [$];
  logic [31:0]      rec_c   [$];
  logic [PLD_W-1:0] exp_payload [$];
  arb_sel_e         exp_tag     [$];

  logic stall;
  logic new_pending;
  logic haz_full_s;
  logic run_started;
  int   cycle_count;
  int   cycle_limit;
  int   exp_total;

  lsu_replay_top i_dut (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_haz_valid           (i_haz_valid),
    .i_haz_payload         (i_haz_payload),
    .i_haz_type            (i_haz_type),
    .i_haz_index           (i_haz_index),
    .o_haz_full            (o_haz_full),
    .i_missu_full          (i_missu_full),
    .i_missu_resolve_valid (i_missu_resolve_valid),
    .i_missu_resolve_oh    (i_missu_resolve_oh),
    .i_missu_entry_valids  (i_missu_entry_valids),
    .i_stq_resolve_mask    (i_stq_resolve_mask),
    .i_flush               (i_flush),
    .i_new_valid           (i_new_valid),
    .i_new_payload         (i_new_payload),
    .o_new_ready           (o_new_ready),
    .o_pipe_valid          (o_pipe_valid),
    .o_pipe_payload        (o_pipe_payload),
    .o_pipe_is_replay      (o_pipe_is_replay),
    .i_pipe_ready          (i_pipe_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // ----------------------------------------------------------------------
  // error path and compares
  // ----------------------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_payload(input logic [PLD_W-1:0] got, input logic [PLD_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: pipe payload %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_tag(input arb_sel_e got, input arb_sel_e exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: replay tag %s, expected %s for payload %h",
                          $time, got.name(), exp.name(), o_pipe_payload));
    end
  endtask

  task automatic check_full(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: queue full flag %b, expected %b", $time, got, exp));
    end
  endtask

  // ----------------------------------------------------------------------
  // one clock: sample at negedge, drive at posedge
  // ----------------------------------------------------------------------

  task automatic tick();
    logic new_taken;
    @(negedge i_clk);
    new_taken  = i_new_valid && o_new_ready;
    haz_full_s = o_haz_full;
    @(posedge i_clk);
    if (new_taken) begin
      i_new_valid <= 1'b0;
      new_pending = 1'b0;
    end
    i_haz_valid           <= 1'b0;
    i_flush               <= 1'b0;
    i_missu_resolve_valid <= 1'b0;
    i_pipe_ready          <= stall ? 1'b0 : (($urandom % 4) != 0);
  endtask

  // every pipe handshake takes the next expect record
  always @(negedge i_clk) begin
    if (i_reset_n && o_pipe_valid && i_pipe_ready) begin
      if (exp_payload.size() == 0) begin
        abort_run($sformatf("unexpected pipe output %h with no expect record left",
                            o_pipe_payload));
      end else begin
        check_payload(o_pipe_payload, exp_payload.pop_front());
        check_tag(o_pipe_is_replay ? SEL_REPLAY : SEL_NEW, exp_tag.pop_front());
      end
    end
  end

  always @(posedge i_clk) begin
    if (run_started) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
        abort_run($sformatf("timeout after %0d cycles, outputs still missing", cycle_count));
      end
    end
  end

  // ----------------------------------------------------------------------
  // golden file load and playback
  // ----------------------------------------------------------------------

  initial begin
    int             fd;
    int             code;
    logic [7:0]     cmd;
    logic [31:0]    a;
    logic [31:0]    b;
    logic [31:0]    c;
    logic [8*128-1:0] skip_line;

    void'($urandom(58706));
    i_reset_n             = 1'b0;
    i_haz_valid           = 1'b0;
    i_haz_payload         = '0;
    i_haz_type            = HAZ_L1D_CONFLICT;
    i_haz_index           = '0;
    i_missu_full          = 1'b0;
    i_missu_resolve_valid = 1'b0;
    i_missu_resolve_oh    = '0;
    i_missu_entry_valids  = '1;
    i_stq_resolve_mask    = '0;
    i_flush               = 1'b0;
    i_new_valid           = 1'b0;
    i_new_payload         = '0;
    i_pipe_ready          = 1'b0;
    stall                 = 1'b0;
    new_pending           = 1'b0;
    haz_full_s            = 1'b0;
    run_started           = 1'b0;
    cycle_count           = 0;
    cycle_limit           = 0;
    exp_total             = 0;

    fd = $fopen("bench/replay_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open bench/replay_golden.txt");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) break;
      a = '0;
      b = '0;
      c = '0;
      case (cmd)
        "#":                     code = $fgets(skip_line, fd);
        "H", "R":                code = $fscanf(fd, "%h %h %h", a, b, c);
        "E":                     code = $fscanf(fd, "%h %h", a, b);
        "N", "M", "P", "W", "C": code = $fscanf(fd, "%h", a);
        "F", "D":                code = 0;
        default: abort_run($sformatf("unknown record type '%c' in golden file", cmd));
      endcase
      if (cmd == "E") begin
        exp_payload.push_back(a[PLD_W-1:0]);
        exp_tag.push_back(arb_sel_e'(b[1:0]));
      end else if (cmd != "#") begin
        // a drain covers every expect record read before it
        if (cmd == "D") begin
          a = exp_payload.size();
        end
        rec_cmd.push_back(cmd);
        rec_a.push_back(a);
        rec_b.push_back(b);
        rec_c.push_back(c);
      end
    end
    $fclose(fd);
    exp_total   = exp_payload.size();
    cycle_limit = (rec_cmd.size() + exp_payload.size()) * 2 * `LSU_RQ_DEPTH + 300;

    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;
    run_started = 1'b1;

    for (int r = 0; r < rec_cmd.size(); r++) begin
      case (rec_cmd[r])
        "H": begin
          // let the previous push land before looking at full
          tick();
          do tick(); while (haz_full_s);
          i_haz_valid   <= 1'b1;
          i_haz_type    <= haz_type_e'(rec_a[r][2:0]);
          i_haz_index   <= rec_b[r][IDX_W-1:0];
          i_haz_payload <= rec_c[r][PLD_W-1:0];
        end
        "N": begin
          do tick(); while (new_pending);
          i_new_valid   <= 1'b1;
          i_new_payload <= rec_a[r][PLD_W-1:0];
          new_pending = 1'b1;
        end
        "R": begin
          tick();
          i_stq_resolve_mask   <= rec_a[r][IDX_W-1:0];
          i_missu_full         <= rec_b[r][0];
          i_missu_entry_valids <= rec_c[r][IDX_W-1:0];
        end
        "M": begin
          tick();
          i_missu_resolve_valid <= 1'b1;
          i_missu_resolve_oh    <= rec_a[r][IDX_W-1:0];
        end
        "F": begin
          tick();
          i_flush <= 1'b1;
        end
        "P": stall = (rec_a[r] == 0);
        "W": repeat (rec_a[r]) tick();
        "C": begin
          tick();
          tick();
          check_full(haz_full_s, rec_a[r][0]);
        end
        default: begin
          // drain until the outputs expected so far have been seen
          do tick();
          while (((exp_total - exp_payload.size()) < int'(rec_a[r])) || new_pending);
        end
      endcase
    end

    repeat (2 * `LSU_RQ_DEPTH) tick();
    if (exp_payload.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      abort_run($sformatf("%0d expect records never matched an output", exp_payload.size()));
    end
  end

endmodule

`default_nettype wire

//--- bench/replay_golden.txt
# records: H type index payload | N payload | R stq_mask missu_full entry_valids | M resolve_oh
# F flush | P ready_mode | W cycles | C full | D drain | E payload tag (1 new, 2 replay), hex
H 1 01 00000101
H 1 02 00000102
E 00000101 2
E 00000102 2
D
C 0
R 00 1 ff
H 2 01 00000201
N 00000202
E 00000202 1
W a
R 00 0 ff
E 00000201 2
D
H 3 01 00000211
H 2 02 00000212
M 01
E 00000211 2
E 00000212 2
D
H 0 01 00000301
N 00000302
E 00000302 1
W a
R 01 0 ff
E 00000301 2
D
H 0 04 00000321
E 00000321 2
D
P 0
H 1 01 00000401
H 1 02 00000402
H 1 04 00000403
F
P 1
N 00000404
E 00000404 1
D
P 0
H 1 01 00000501
H 1 01 00000502
H 1 01 00000503
H 1 01 00000504
H 1 01 00000505
H 1 01 00000506
H 1 01 00000507
H 1 01 00000508
C 1
N 000005ff
W 3
P 1
E 00000501 2
E 00000502 2
E 00000503 2
E 00000504 2
E 00000505 2
E 00000506 2
E 00000507 2
E 00000508 2
E 000005ff 1
D

//--- src.f
+incdir+source
source/lsu_pkg.sv
source/ring_fifo.sv
source/lsu_replay_queue.sv
source/lsu_pipe_arbiter.sv
source/lsu_replay_top.sv
bench/tb_lsu_replay.sv

//--- Makefile
TOP = tb_lsu_replay

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -f src.f --top-module lsu_replay_top

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | grep -F "Simulation passed"

clean:
	rm -rf obj_dir
